// File: source/front_end_pkg.sv
package front_end_pkg;

    // Byte lanes in one incoming line.
    localparam int FETCH_WIDTH = 16;

    // Head bytes shown to the length decoder.
    localparam int WINDOW_LEN = 8;

    // Longest instruction in bytes.
    localparam int MAX_INST_LEN = 6;

    // Instruction address width.
    localparam int ADDR_W = 32;

    // Count widths derived from the sizes above.
    localparam int LINE_CNT_W = $clog2(FETCH_WIDTH + 1);
    localparam int WIN_CNT_W = $clog2(WINDOW_LEN + 1);
    localparam int LEN_W = $clog2(MAX_INST_LEN + 1);

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [LINE_CNT_W-1:0] line_cnt_t;
    typedef logic [WIN_CNT_W-1:0] win_cnt_t;
    typedef logic [LEN_W-1:0] len_t;

    // Opcode class, coded as the low three bits of the head byte.
    typedef enum logic [2:0] {
        class_alu     = 3'b100,
        class_mem_io  = 3'b010,
        class_flow    = 3'b110,
        class_illegal = 3'b000
    } inst_class_e;

    // One decoded instruction as held in the queue.
    typedef struct packed {
        logic [MAX_INST_LEN-1:0][7:0] inst;   // byte 0 is the opcode, unused bytes zero
        addr_t                        addr;
        len_t                         len;
        inst_class_e                  cls;
    } queued_inst_t;

endpackage

// File: source/byte_buffer.sv
module byte_buffer #(
    parameter int IDB_LEN = 64
) (
    input  logic                                          clk,
    input  logic                                          arst_n,
    input  logic                                          flush,
    input  logic                                          line_valid,
    input  logic [front_end_pkg::FETCH_WIDTH-1:0][7:0]    line_bytes,
    input  front_end_pkg::line_cnt_t                      line_count,
    input  front_end_pkg::len_t                           take_len,
    output logic                                          line_ready,
    output logic [front_end_pkg::WINDOW_LEN-1:0][7:0]     window,
    output front_end_pkg::win_cnt_t                       avail
);
    localparam int CNT_W = $clog2(IDB_LEN + 1);

    // Byte 0 is always the oldest byte in the buffer.
    logic [IDB_LEN-1:0][7:0] mem;
    logic [IDB_LEN-1:0][7:0] mem_next;

    // Fill count, and what is left of it after the pop.
    logic [CNT_W-1:0] cnt;
    logic [CNT_W-1:0] cnt_kept;
    logic [CNT_W-1:0] cnt_next;
    logic             accept;

    // Room for a full line, and no intake in the cycle of a jump.
    assign line_ready = (cnt <= CNT_W'(IDB_LEN - front_end_pkg::FETCH_WIDTH)) && !flush;
    assign accept = line_valid && line_ready;

    assign cnt_kept = cnt - CNT_W'(take_len);
    assign cnt_next = accept ? cnt_kept + CNT_W'(line_count) : cnt_kept;

    // Pop the head bytes first.
    // New bytes then land right behind the ones that stay.
    always_comb begin
        mem_next = mem >> (8 * take_len);
        for (int j = 0; j < front_end_pkg::FETCH_WIDTH; j++) begin
            if (accept && j < int'(line_count) && int'(cnt_kept) + j < IDB_LEN) begin
                mem_next[int'(cnt_kept) + j] = line_bytes[j];
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt <= '0;
        end else if (flush) begin
            // Jump drops every buffered byte.
            cnt <= '0;
        end else begin
            cnt <= cnt_next;
        end
    end

    // Byte storage, rewritten every cycle.
    always_ff @(posedge clk) begin
        mem <= mem_next;
    end

    // Stale bytes past the fill count read as zero.
    always_comb begin
        for (int i = 0; i < front_end_pkg::WINDOW_LEN; i++) begin
            window[i] = (CNT_W'(i) < cnt) ? mem[i] : 8'h00;
        end
    end

    // Valid window bytes, saturated at the window size.
    assign avail = (cnt >= CNT_W'(front_end_pkg::WINDOW_LEN)) ?
                   front_end_pkg::win_cnt_t'(front_end_pkg::WINDOW_LEN) :
                   front_end_pkg::win_cnt_t'(cnt);

    // The decoder pops only bytes it has been shown.
    assert property (@(posedge clk) disable iff (!arst_n)
        int'(take_len) <= int'(avail));

    // The source keeps line_count in range, so a line always fits.
    assert property (@(posedge clk) disable iff (!arst_n)
        accept |-> (line_count != '0) && (int'(cnt_kept) + int'(line_count) <= IDB_LEN));

endmodule

// File: source/length_decoder.sv
module length_decoder (
    input  logic                                          clk,
    input  logic                                          arst_n,
    input  logic                                          flush,
    input  front_end_pkg::addr_t                          jmp_addr,
    input  logic [front_end_pkg::WINDOW_LEN-1:0][7:0]     window,
    input  front_end_pkg::win_cnt_t                       avail,
    input  logic                                          full,
    output front_end_pkg::len_t                           take_len,
    output logic                                          push,
    output front_end_pkg::queued_inst_t                   entry
);
    // Opcode byte at the head of the buffer.
    logic [7:0] head;

    front_end_pkg::inst_class_e cls;
    front_end_pkg::len_t        len;

    // Address of the instruction at the buffer head.
    front_end_pkg::addr_t addr;

    // Every byte of the head instruction is present.
    logic complete;

    assign head = window[0];

    // Class from bits 2:0, length from the mode bits 4:3.
    always_comb begin
        case (head[2:0])
            front_end_pkg::class_alu: begin
                cls = front_end_pkg::class_alu;
                len = head[3] ? 3'd6 : 3'd2;
            end
            front_end_pkg::class_mem_io: begin
                cls = front_end_pkg::class_mem_io;
                // Register form is short, else load/store or port IO.
                if (head[3]) begin
                    len = 3'd2;
                end else begin
                    len = head[4] ? 3'd3 : 3'd6;
                end
            end
            front_end_pkg::class_flow: begin
                cls = front_end_pkg::class_flow;
                len = head[3] ? 3'd5 : 3'd1;
            end
            default: begin
                // Unknown opcode, consumed alone so decoding goes on.
                cls = front_end_pkg::class_illegal;
                len = 3'd1;
            end
        endcase
    end

    assign complete = avail >= front_end_pkg::win_cnt_t'(len);

    // One instruction per cycle, only while the queue has room.
    assign push = complete && !full;
    assign take_len = push ? len : '0;

    always_comb begin
        entry = '0;
        for (int i = 0; i < front_end_pkg::MAX_INST_LEN; i++) begin
            if (i < int'(len)) begin
                entry.inst[i] = window[i];
            end
        end
        entry.addr = addr;
        entry.len = len;
        entry.cls = cls;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            addr <= '0;
        end else if (flush) begin
            // Jump target becomes the next head address.
            addr <= jmp_addr;
        end else if (push) begin
            addr <= addr + front_end_pkg::addr_t'(len);
        end
    end

endmodule

// File: source/instruction_queue.sv
module instruction_queue #(
    parameter int IQ_LEN = 8
) (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         flush,
    input  logic                         push,
    input  front_end_pkg::queued_inst_t  entry,
    input  logic                         iq_pop,
    output logic                         full,
    output logic                         iq_valid,
    output front_end_pkg::queued_inst_t  head
);
    localparam int PTR_W = $clog2(IQ_LEN);
    localparam int CNT_W = $clog2(IQ_LEN + 1);

    front_end_pkg::queued_inst_t slots [IQ_LEN];

    // Pointers wrap on their own since the depth is a power of two.
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;

    // Pops on an empty queue are dropped here.
    logic do_pop;

    assign full = count == CNT_W'(IQ_LEN);
    assign iq_valid = count != '0;
    assign do_pop = iq_pop && iq_valid;
    assign head = slots[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            slots[wr_ptr] <= entry;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else if (flush) begin
            // Jump discards everything queued.
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + PTR_W'(1);
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + PTR_W'(1);
            end
            // Push and pop together leave the count alone.
            case ({push, do_pop})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;
            endcase
        end
    end

    // The decoder holds back while the queue is full.
    assert property (@(posedge clk) disable iff (!arst_n) full |-> !push);

endmodule

// File: source/instruction_front_end.sv
module instruction_front_end #(
    parameter int IDB_LEN = 64,
    parameter int IQ_LEN  = 8
) (
    input  logic                                            clk,
    input  logic                                            arst_n,

    // Line intake.
    input  logic                                            line_valid,
    input  logic [front_end_pkg::FETCH_WIDTH-1:0][7:0]      line_bytes,
    input  front_end_pkg::line_cnt_t                        line_count,
    output logic                                            line_ready,

    // Decoded instructions toward the back end.
    output logic                                            iq_valid,
    input  logic                                            iq_pop,
    output logic [front_end_pkg::MAX_INST_LEN-1:0][7:0]     iq_inst,
    output front_end_pkg::addr_t                            iq_addr,
    output front_end_pkg::len_t                             iq_len,
    output front_end_pkg::inst_class_e                      iq_class,

    // Jump from the back end.
    input  logic                                            jmp,
    input  front_end_pkg::addr_t                            jmp_addr
);
    // Buffer head as seen by the decoder.
    logic [front_end_pkg::WINDOW_LEN-1:0][7:0] window;
    front_end_pkg::win_cnt_t                   avail;
    front_end_pkg::len_t                       take_len;

    // Decoder to queue.
    logic                        push;
    logic                        full;
    front_end_pkg::queued_inst_t entry;
    front_end_pkg::queued_inst_t head;

    byte_buffer #(.IDB_LEN(IDB_LEN)) i_byte_buffer (
        .clk(clk), .arst_n(arst_n), .flush(jmp),
        .line_valid(line_valid), .line_bytes(line_bytes), .line_count(line_count),
        .take_len(take_len), .line_ready(line_ready), .window(window), .avail(avail)
    );

    length_decoder i_length_decoder (
        .clk(clk), .arst_n(arst_n), .flush(jmp), .jmp_addr(jmp_addr),
        .window(window), .avail(avail), .full(full),
        .take_len(take_len), .push(push), .entry(entry)
    );

    instruction_queue #(.IQ_LEN(IQ_LEN)) i_instruction_queue (
        .clk(clk), .arst_n(arst_n), .flush(jmp), .push(push), .entry(entry),
        .iq_pop(iq_pop), .full(full), .iq_valid(iq_valid), .head(head)
    );

    // Queue head split into its fields.
    assign iq_inst = head.inst;
    assign iq_addr = head.addr;
    assign iq_len = head.len;
    assign iq_class = head.cls;

endmodule

// File: verification/tb_stimulus.svh
// One table row per instruction.
// Columns are the opcode byte, a jump flag and the jump target.
// A set jump flag jumps to the target right before that row.
typedef struct packed {
    logic [7:0]           head;
    logic                 jump;
    front_end_pkg::addr_t jaddr;
} stim_t;

localparam int N_ENTRIES = 32;

localparam stim_t stim_table [N_ENTRIES] = '{
    // Short run with every class once.
    '{8'h04, 1'b1, 32'h0000_1000},
    '{8'h0C, 1'b0, 32'h0},
    '{8'h12, 1'b0, 32'h0},
    '{8'h06, 1'b0, 32'h0},
    '{8'h07, 1'b0, 32'h0},
    '{8'h02, 1'b0, 32'h0},
    // Long run, enough bytes to back up the buffer.
    '{8'hE4, 1'b1, 32'h0004_0000},
    '{8'h0A, 1'b0, 32'h0},
    '{8'h0E, 1'b0, 32'h0},
    '{8'h1C, 1'b0, 32'h0},
    '{8'h02, 1'b0, 32'h0},
    '{8'h0C, 1'b0, 32'h0},
    '{8'h42, 1'b0, 32'h0},
    '{8'h0E, 1'b0, 32'h0},
    '{8'h03, 1'b0, 32'h0},
    '{8'h1C, 1'b0, 32'h0},
    '{8'h02, 1'b0, 32'h0},
    '{8'h8C, 1'b0, 32'h0},
    '{8'h0E, 1'b0, 32'h0},
    '{8'h1A, 1'b0, 32'h0},
    '{8'h0C, 1'b0, 32'h0},
    '{8'h02, 1'b0, 32'h0},
    '{8'h2E, 1'b0, 32'h0},
    '{8'h1C, 1'b0, 32'h0},
    '{8'h00, 1'b0, 32'h0},
    '{8'h02, 1'b0, 32'h0},
    // Target near the top, so the address wraps.
    '{8'h16, 1'b1, 32'hFFFF_FFF8},
    '{8'h14, 1'b0, 32'h0},
    '{8'h81, 1'b0, 32'h0},
    '{8'h1E, 1'b0, 32'h0},
    '{8'h32, 1'b0, 32'h0},
    '{8'h0E, 1'b0, 32'h0}
};

// File: verification/tb_front_end.sv
module tb_front_end;

    `include "tb_stimulus.svh"

    // Number of passes over the table.
    localparam int N_RUNS = 3;

    // Expected queue entry.
    typedef struct packed {
        logic [front_end_pkg::MAX_INST_LEN-1:0][7:0] inst;
        front_end_pkg::addr_t                        addr;
        front_end_pkg::len_t                         len;
        front_end_pkg::inst_class_e                  cls;
    } exp_t;

    logic                                       clk;
    logic                                       arst_n;
    logic                                       line_valid;
    logic [front_end_pkg::FETCH_WIDTH-1:0][7:0] line_bytes;
    front_end_pkg::line_cnt_t                   line_count;
    logic                                       line_ready;
    logic                                       iq_valid;
    logic                                       iq_pop;
    logic [front_end_pkg::MAX_INST_LEN-1:0][7:0] iq_inst;
    front_end_pkg::addr_t                       iq_addr;
    front_end_pkg::len_t                        iq_len;
    front_end_pkg::inst_class_e                 iq_class;
    logic                                       jmp;
    front_end_pkg::addr_t                       jmp_addr;

    exp_t       exp_q [$];
    logic [7:0] byte_q [$];
    int         seed = 27;
    // Pop gaps draw from their own stream, apart from the line driver.
    int         pop_seed = 27;
    int         errors = 0;
    int         checks = 0;
    int         tests = 0;
    int         failed_tests = 0;
    bit         saw_ready_low;
    bit         drive_done;

    instruction_front_end #(.IDB_LEN(64), .IQ_LEN(8)) i_dut (
        .clk(clk), .arst_n(arst_n),
        .line_valid(line_valid), .line_bytes(line_bytes), .line_count(line_count),
        .line_ready(line_ready), .iq_valid(iq_valid), .iq_pop(iq_pop),
        .iq_inst(iq_inst), .iq_addr(iq_addr), .iq_len(iq_len), .iq_class(iq_class),
        .jmp(jmp), .jmp_addr(jmp_addr)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // Run limit from the table length.
    initial begin
        repeat (N_RUNS * 40 * N_ENTRIES + 200) @(posedge clk);
        $display("timeout, the front end stopped delivering instructions");
        $display("Simulation finished: FAIL");
        $finish;
    end

    // Length rules for the opcode byte.
    function automatic int ref_len(input logic [7:0] op);
        case (op[2:0])
            3'b100:  return op[3] ? 6 : 2;
            3'b010:  return op[3] ? 2 : (op[4] ? 3 : 6);
            3'b110:  return op[3] ? 5 : 1;
            default: return 1;
        endcase
    endfunction

    function automatic front_end_pkg::inst_class_e ref_class(input logic [7:0] op);
        case (op[2:0])
            3'b100:  return front_end_pkg::class_alu;
            3'b010:  return front_end_pkg::class_mem_io;
            3'b110:  return front_end_pkg::class_flow;
            default: return front_end_pkg::class_illegal;
        endcase
    endfunction

    // All stimulus moves 2 units after the rising edge.
    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic value_error(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        errors++;
        $display("error at %0t: %s is %0h, expected %0h", $time, name, got, want);
    endtask

    task automatic plain_error(input string msg);
        errors++;
        $display("at %0t: %s", $time, msg);
    endtask

    // Bytes and expected entries from one jump to the next, then junk.
    task automatic build_segment(input int first, output int last);
        exp_t                 e;
        front_end_pkg::addr_t a;
        int                   i;
        a = stim_table[first].jaddr;
        i = first;
        while (i < N_ENTRIES && (i == first || !stim_table[i].jump)) begin
            e = '0;
            e.inst[0] = stim_table[i].head;
            e.len = front_end_pkg::len_t'(ref_len(stim_table[i].head));
            e.cls = ref_class(stim_table[i].head);
            e.addr = a;
            byte_q.push_back(stim_table[i].head);
            for (int k = 1; k < int'(e.len); k++) begin
                e.inst[k] = 8'($random(seed));
                byte_q.push_back(e.inst[k]);
            end
            exp_q.push_back(e);
            a = a + front_end_pkg::addr_t'(e.len);
            i++;
        end
        // Trailing junk is meant to be flushed by the next jump.
        repeat (12) byte_q.push_back(8'($random(seed)));
        last = i;
    endtask

    task automatic drive_stream(input bit one_byte);
        int idx;
        int n;
        bit ok;
        idx = 0;
        while (idx < byte_q.size()) begin
            n = one_byte ? 1 : 1 + ({$random(seed)} % front_end_pkg::FETCH_WIDTH);
            if (n > byte_q.size() - idx) begin
                n = byte_q.size() - idx;
            end
            line_bytes = '0;
            for (int j = 0; j < n; j++) begin
                line_bytes[j] = byte_q[idx + j];
            end
            line_count = front_end_pkg::line_cnt_t'(n);
            line_valid = 1'b1;
            ok = 1'b0;
            // Hold the line until the edge that takes it.
            while (!ok) begin
                ok = line_ready;
                step();
            end
            idx += n;
            line_valid = 1'b0;
        end
        byte_q.delete();
        drive_done = 1'b1;
    endtask

    task automatic compare_head(input exp_t e);
        checks += 4;
        assert (iq_addr == e.addr) else value_error("iq_addr", iq_addr, e.addr);
        assert (iq_len == e.len) else value_error("iq_len", iq_len, e.len);
        assert (iq_class == e.cls) else value_error("iq_class", iq_class, e.cls);
        assert (iq_inst == e.inst) else value_error("iq_inst", iq_inst, e.inst);
    endtask

    // Pop with random gaps; hold pops first until line_ready falls.
    task automatic check_stream(input bit hold);
        exp_t e;
        bit   released;
        released = !hold;
        while (exp_q.size() > 0) begin
            if (!released && (!line_ready || drive_done)) begin
                if (!line_ready) begin
                    saw_ready_low = 1'b1;
                end
                released = 1'b1;
            end
            iq_pop = 1'b0;
            if (released && iq_valid && ({$random(pop_seed)} % 4 != 0)) begin
                e = exp_q.pop_front();
                compare_head(e);
                iq_pop = 1'b1;
            end
            step();
        end
        iq_pop = 1'b0;
    endtask

    task automatic jump_to(input front_end_pkg::addr_t target);
        jmp = 1'b1;
        jmp_addr = target;
        step();
        jmp = 1'b0;
        checks++;
        assert (!iq_valid) else value_error("iq_valid", iq_valid, 0);
        // One quiet cycle, so line_ready has settled before the stream starts.
        step();
    endtask

    task automatic finish_test(input string name, input int err0);
        tests++;
        if (errors == err0) begin
            $display("test %s: passed", name);
        end else begin
            failed_tests++;
            $display("test %s: failed with %0d errors", name, errors - err0);
        end
    endtask

    task automatic run_table(input string name, input bit one_byte, input bit hold);
        int first;
        int last;
        int err0;
        err0 = errors;
        first = 0;
        saw_ready_low = 1'b0;
        while (first < N_ENTRIES) begin
            build_segment(first, last);
            jump_to(stim_table[first].jaddr);
            drive_done = 1'b0;
            fork
                drive_stream(one_byte);
                check_stream(hold);
            join
            // Let the junk reach the queue before the next jump.
            repeat (4) step();
            first = last;
        end
        if (hold) begin
            checks++;
            assert (saw_ready_low)
                else plain_error("line_ready never fell while pops were held");
        end
        finish_test(name, err0);
    endtask

    initial begin
        int err0;
        arst_n = 1'b0;
        line_valid = 1'b0;
        line_bytes = '0;
        line_count = '0;
        iq_pop = 1'b0;
        jmp = 1'b0;
        jmp_addr = '0;
        repeat (4) @(posedge clk);
        #2;
        arst_n = 1'b1;
        step();

        err0 = errors;
        checks += 2;
        assert (!iq_valid) else value_error("iq_valid", iq_valid, 0);
        assert (line_ready) else value_error("line_ready", line_ready, 1);
        finish_test("reset", err0);

        // Jumps and illegal opcodes are part of every pass.
        run_table("classes_in_order", 1'b0, 1'b0);
        run_table("one_byte_lines", 1'b1, 1'b0);
        run_table("back_pressure", 1'b0, 1'b1);

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+verification
source/front_end_pkg.sv
source/byte_buffer.sv
source/length_decoder.sv
source/instruction_queue.sv
source/instruction_front_end.sv
verification/tb_front_end.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, and pass only if the pass line shows up.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_front_end \
    && ./obj_dir/Vtb_front_end | tee /dev/stderr | grep -qF "Simulation finished: PASS" \
    && exit 0 || exit 1
